/* rtl/mlp_pkg.sv */
// sizes, input word views and sequencer states for the classifier layer
// imported by every rtl block, the testbench and the bound checker
package mlp_pkg;

	localparam int num_rows = 4;    // rows of neurons
	localparam int num_lanes = 4;   // neurons per row, 16 in all
	localparam int num_inputs = 8;  // weight beats per row
	localparam int bank_lanes = 2;  // lanes held by one bank

	localparam int pixel_w = 16;
	localparam int weight_w = 16;
	localparam int acc_w = 32;      // sums and biases, wrap mod 2^32
	localparam int index_w = 4;     // neuron index 0..15
	localparam int row_w = 2;
	localparam int beat_w = 3;

	// bias beats per row, one per bank half
	localparam int num_halves = num_lanes / bank_lanes;
	localparam int bias_beats = num_rows * num_halves;  // 8, fits beat counter
	localparam int finish_cycles = 2;  // drain of bank and merge stages

	// sum, bias or activation
	typedef logic signed [acc_w-1:0] acc_t;

	// one 64 bit input beat
	// weight beats carry four lane weights, bias beats carry two biases
	typedef union packed {
		logic [num_lanes-1:0][weight_w-1:0] weights;  // lane 0 in low bits
		acc_t [bank_lanes-1:0] biases;                // low word = first lane of the half
	} data_word_t;

	typedef enum logic [2:0] {
		seq_idle,
		seq_weights,  // 32 mac beats
		seq_biases,   // 8 bias beats
		seq_finish,   // wait for bank and merge
		seq_done      // result held until next start
	} seq_state_t;

endpackage

/* rtl/bank_if.sv */
// registered input beat from the sequencer, fanned out to both neuron banks
// seq drives every signal, each bank only listens
`timescale 1ns/1ps

interface bank_if
	import mlp_pkg::*;
();

	logic mac_en;                // weight beat strobe
	logic bias_en;               // bias beat strobe
	logic bias_half;             // 0: lanes 0-1, 1: lanes 2-3
	logic [row_w-1:0] row;       // row the beat belongs to
	logic [pixel_w-1:0] pixel;   // only valid with mac_en
	data_word_t word;            // weights or biases

	modport seq (
		output mac_en, bias_en, bias_half, row, pixel, word
	);

	modport bank (
		input mac_en, bias_en, bias_half, row, pixel, word
	);

endinterface

/* rtl/layer_seq.sv */
// beat counting FSM for one classification run
// takes start and data_valid beats, copies each accepted beat onto bank_if
`timescale 1ns/1ps

module layer_seq
	import mlp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic data_valid,
	input logic [pixel_w-1:0] pixel,
	input data_word_t data,
	bank_if.seq bus,
	output logic clear_row,
	output logic busy,
	output logic done
);

	localparam logic [beat_w-1:0] last_weight = beat_w'(num_inputs - 1);
	localparam logic [beat_w-1:0] last_bias = beat_w'(bias_beats - 1);
	localparam logic [beat_w-1:0] last_finish = beat_w'(finish_cycles);
	localparam logic [row_w-1:0] last_row = row_w'(num_rows - 1);

	seq_state_t state;
	logic [beat_w-1:0] beat;  // beat in row, bias beat, or finish count
	logic [row_w-1:0] row;
	logic take_weight;
	logic take_bias;

	assign take_weight = data_valid && (state == seq_weights);
	assign take_bias = data_valid && (state == seq_biases);  // no back-pressure

	assign busy = (state == seq_weights) || (state == seq_biases) || (state == seq_finish);
	assign done = (state == seq_done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_idle;
			beat <= '0;
			row <= '0;
		end else begin
			case (state)
				seq_idle, seq_done: begin
					if (start) begin  // start elsewhere is dropped
						state <= seq_weights;
						beat <= '0;
						row <= '0;
					end
				end
				seq_weights: begin
					if (take_weight) begin
						if (beat == last_weight) begin
							beat <= '0;
							row <= row + 1'b1;  // wraps back to 0 after row 3
							if (row == last_row)
								state <= seq_biases;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				seq_biases: begin
					if (take_bias) begin
						if (beat == last_bias) begin
							beat <= '0;
							state <= seq_finish;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				seq_finish: begin
					// bank max one edge, merge register next, done with it
					if (beat == last_finish)
						state <= seq_done;
					else
						beat <= beat + 1'b1;
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// strobes, one cycle behind the sampling edge
	always_ff @(posedge clk) begin
		if (reset) begin
			bus.mac_en <= 1'b0;
			bus.bias_en <= 1'b0;
			clear_row <= 1'b0;
		end else begin
			bus.mac_en <= take_weight;
			bus.bias_en <= take_bias;
			clear_row <= take_weight && (beat == '0);  // first pixel of a row
		end
	end

	// beat payload
	always_ff @(posedge clk) begin
		if (take_weight) begin
			bus.pixel <= pixel;  // pixel ignored on bias beats
			bus.row <= row;
		end
		if (take_bias) begin
			bus.row <= beat[beat_w-1:1];   // two bias beats per row
			bus.bias_half <= beat[0];      // even beat low lanes, odd beat high lanes
		end
		if (take_weight || take_bias)
			bus.word <= data;
	end

endmodule

/* rtl/neuron_bank.sv */
// two neuron lanes for every row: signed mac, bias add, relu, running argmax
// instantiated once per bank half, lane_base 0 or 2
`timescale 1ns/1ps

module neuron_bank
	import mlp_pkg::*;
#(
	parameter int lane_base = 0
) (
	input logic clk,
	input logic reset,
	bank_if.bank bus,
	input logic clear_row,
	output acc_t best_value,
	output logic [index_w-1:0] best_index,
	output logic row_done
);

	localparam logic my_half = 1'(lane_base / bank_lanes);  // which bias beat is ours

	acc_t acc [num_rows][bank_lanes];  // raw weighted sums
	acc_t prod [bank_lanes];
	acc_t act [bank_lanes];            // after bias and relu
	acc_t pick_value;                  // best lane of the current row
	logic [index_w-1:0] pick_index;
	logic bias_hit;
	logic run_start;

	assign bias_hit = bus.bias_en && (bus.bias_half == my_half);
	assign run_start = bus.mac_en && clear_row && (bus.row == '0);  // first beat of a run

	// 16x16 signed products, sign extended to 32
	always_comb begin
		for (int l = 0; l < bank_lanes; l++) begin
			prod[l] = $signed(bus.pixel) * $signed(bus.word.weights[lane_base + l]);
		end
	end

	// mac, wraps mod 2^32
	always_ff @(posedge clk) begin
		if (bus.mac_en) begin
			for (int l = 0; l < bank_lanes; l++) begin
				if (clear_row)
					acc[bus.row][l] <= prod[l];  // load on pixel 0
				else
					acc[bus.row][l] <= acc[bus.row][l] + prod[l];
			end
		end
	end

	// bias then relu, read straight from the row's accumulators
	always_comb begin
		acc_t sum;
		for (int l = 0; l < bank_lanes; l++) begin
			sum = acc[bus.row][l] + bus.word.biases[l];
			act[l] = sum[acc_w-1] ? '0 : sum;  // negative to zero
		end
	end

	// fold lanes, strict compare keeps the lower lane on a tie
	always_comb begin
		pick_value = act[0];
		pick_index = index_w'(int'(bus.row) * num_lanes + lane_base);
		for (int l = 1; l < bank_lanes; l++) begin
			if (act[l] > pick_value) begin
				pick_value = act[l];
				pick_index = index_w'(int'(bus.row) * num_lanes + lane_base + l);
			end
		end
	end

	// running max over rows, rows arrive in order so earlier index wins ties
	always_ff @(posedge clk) begin
		if (reset || run_start) begin
			best_value <= '0;
			best_index <= index_w'(lane_base);  // all-zero net picks the lowest lane
		end else if (bias_hit && (pick_value > best_value)) begin
			best_value <= pick_value;
			best_index <= pick_index;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			row_done <= 1'b0;
		else
			row_done <= bias_hit;  // one pulse per row, max already updated
	end

endmodule

/* rtl/max_merge.sv */
// picks the larger of the two bank maxima and holds it as the prediction
// loads on every high bank row_done, the pulse of row 3 leaves the final pick
`timescale 1ns/1ps

module max_merge
	import mlp_pkg::*;
(
	input logic clk,
	input logic reset,
	input acc_t value_a,
	input acc_t value_b,
	input logic [index_w-1:0] index_a,
	input logic [index_w-1:0] index_b,
	input logic final_strobe,
	output logic [index_w-1:0] index_pred,
	output acc_t best_value
);

	logic take_b;

	// bank b can hold the lower index, e.g. 2 against 4
	// so a tie is settled by the index itself
	assign take_b = (value_b > value_a) ||
		((value_b == value_a) && (index_b < index_a));

	always_ff @(posedge clk) begin
		if (reset) begin
			index_pred <= '0;
			best_value <= '0;
		end else if (final_strobe) begin
			if (take_b) begin
				index_pred <= index_b;
				best_value <= value_b;
			end else begin
				index_pred <= index_a;
				best_value <= value_a;
			end
		end
	end

endmodule

/* rtl/mlp_classifier.sv */
// top of the 16 neuron classifier layer: sequencer, two banks and merge
// stream 32 weight beats then 8 bias beats after start, read result on done
`timescale 1ns/1ps

module mlp_classifier
	import mlp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic data_valid,
	input logic [pixel_w-1:0] pixel,
	input data_word_t data,
	output logic busy,
	output logic done,
	output logic [index_w-1:0] index_pred,
	output acc_t best_value
);

	bank_if bus ();  // shared beat to both banks

	logic clear_row;
	acc_t value_lo;
	acc_t value_hi;
	logic [index_w-1:0] index_lo;
	logic [index_w-1:0] index_hi;
	logic row_done_hi;

	layer_seq layer_seq_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_valid(data_valid),
		.pixel(pixel),
		.data(data),
		.bus(bus),
		.clear_row(clear_row),
		.busy(busy),
		.done(done)
	);

	// lanes 0-1, low bias beat
	neuron_bank #(.lane_base(0)) bank_lo_inst (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.clear_row(clear_row),
		.best_value(value_lo),
		.best_index(index_lo),
		.row_done()  // low half always lands a cycle before the high half
	);

	// lanes 2-3, high bias beat
	neuron_bank #(.lane_base(2)) bank_hi_inst (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.clear_row(clear_row),
		.best_value(value_hi),
		.best_index(index_hi),
		.row_done(row_done_hi)
	);

	max_merge max_merge_inst (
		.clk(clk),
		.reset(reset),
		.value_a(value_lo),
		.value_b(value_hi),
		.index_a(index_lo),
		.index_b(index_hi),
		.final_strobe(row_done_hi),
		.index_pred(index_pred),
		.best_value(best_value)
	);

endmodule

/* dv/mlp_classifier_checker.sv */
// port assertions for the classifier top, attached to every mlp_classifier by bind
`timescale 1ns/1ps

module mlp_classifier_checker
	import mlp_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic [index_w-1:0] index_pred,
	input acc_t best_value
);

	// busy drops on the edge that raises done
	busy_done_apart: assert property (@(posedge clk) disable iff (reset)
		!(busy && done))
		else $error("busy and done high in the same cycle");

	// result held for as long as done is up
	result_held: assert property (@(posedge clk) disable iff (reset)
		(done && $past(done)) |-> ($stable(index_pred) && $stable(best_value)))
		else $error("prediction changed while done was high");

	done_low_after_reset: assert property (@(posedge clk)
		reset |=> !done)
		else $error("done high in the cycle after reset");

endmodule

bind mlp_classifier mlp_classifier_checker mlp_classifier_checker_inst (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.index_pred(index_pred),
	.best_value(best_value)
);

/* dv/mlp_classifier_tb.sv */
// testbench for the classifier layer, directed and random networks against a reference model
// built and run by the Makefile, stops on the first mismatch
`timescale 1ns/1ps

module mlp_classifier_tb
	import mlp_pkg::*;
();

	localparam int num_neurons = num_rows * num_lanes;
	localparam int clk_period = 20;
	localparam int num_runs = 26;  // 3 directed, 20 random, stray, reset pair
	localparam int watchdog_cycles = num_runs * 60 * 4;

	logic clk;
	logic reset;
	logic start;
	logic data_valid;
	logic [pixel_w-1:0] pixel;
	data_word_t data;
	logic busy;
	logic done;
	logic [index_w-1:0] index_pred;
	acc_t best_value;

	// network under test, neuron n = row * 4 + lane
	logic signed [pixel_w-1:0] pixels [num_inputs];
	logic signed [weight_w-1:0] weights [num_neurons][num_inputs];
	acc_t biases [num_neurons];

	mlp_classifier mlp_classifier_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_valid(data_valid),
		.pixel(pixel),
		.data(data),
		.busy(busy),
		.done(done),
		.index_pred(index_pred),
		.best_value(best_value)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired, tests did not finish within %0d cycles", watchdog_cycles);
		abort_run();
	end

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	// wrapped dot product plus bias, relu, argmax with lowest index on ties
	function automatic void reference_classify(output logic [index_w-1:0] idx, output acc_t val);
		longint total;
		acc_t act;
		idx = '0;
		val = '0;
		for (int n = 0; n < num_neurons; n++) begin
			total = longint'(biases[n]);
			for (int i = 0; i < num_inputs; i++)
				total += longint'(pixels[i]) * longint'(weights[n][i]);
			act = acc_t'(total);  // mod 2^32
			if (act < 0)
				act = '0;
			if (act > val) begin  // strict, earlier neuron keeps a tie
				val = act;
				idx = index_w'(n);
			end
		end
	endfunction

	function automatic data_word_t weight_word(input int r, input int i);
		data_word_t w;
		for (int l = 0; l < num_lanes; l++)
			w.weights[l] = weights[r * num_lanes + l][i];
		return w;
	endfunction

	// even beat lanes 0-1 of the row, odd beat lanes 2-3
	function automatic data_word_t bias_word(input int b);
		data_word_t w;
		int base;
		base = (b / 2) * num_lanes + (b % 2) * bank_lanes;
		w.biases[0] = biases[base];
		w.biases[1] = biases[base + 1];
		return w;
	endfunction

	task automatic fill_network(input logic signed [pixel_w-1:0] p,
			input logic signed [weight_w-1:0] w, input acc_t b);
		for (int n = 0; n < num_neurons; n++) begin
			biases[n] = b;
			for (int i = 0; i < num_inputs; i++)
				weights[n][i] = w;
		end
		for (int i = 0; i < num_inputs; i++)
			pixels[i] = p;
	endtask

	task automatic randomize_network();
		for (int n = 0; n < num_neurons; n++) begin
			biases[n] = acc_t'($urandom());
			for (int i = 0; i < num_inputs; i++)
				weights[n][i] = 16'($urandom());  // full signed range
		end
		for (int i = 0; i < num_inputs; i++)
			pixels[i] = 16'($urandom());
	endtask

	// inputs change 2 ns after the edge
	task automatic send_beat(input logic [pixel_w-1:0] p, input data_word_t w,
			input logic with_start);
		@(posedge clk);
		#2;
		start = with_start;
		data_valid = 1'b1;
		pixel = p;
		data = w;
	endtask

	task automatic send_start();
		@(posedge clk);
		#2;
		start = 1'b1;
		data_valid = 1'b0;
	endtask

	task automatic go_quiet();
		@(posedge clk);
		#2;
		start = 1'b0;
		data_valid = 1'b0;
	endtask

	task automatic junk_beats(input int count);
		data_word_t junk;
		for (int k = 0; k < count; k++) begin
			junk = {$urandom(), $urandom()};
			send_beat(16'($urandom()), junk, 1'b0);
		end
	endtask

	task automatic wait_done();
		do
			@(negedge clk);  // outputs settled mid cycle
		while (done !== 1'b1);
	endtask

	task automatic check_index(input logic [index_w-1:0] got, input logic [index_w-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t index_pred got %0d expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_value(input acc_t got, input acc_t exp);
		if (got !== exp) begin
			$display("ERR %0t best_value got %0d expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic run_network(input logic stray);
		logic [index_w-1:0] exp_index;
		acc_t exp_value;
		reference_classify(exp_index, exp_value);
		if (stray)
			junk_beats(3);  // sequencer sits in done here
		send_start();
		for (int r = 0; r < num_rows; r++) begin
			for (int i = 0; i < num_inputs; i++)
				send_beat(pixels[i], weight_word(r, i), stray && (r == 1) && (i == 3));
		end
		for (int b = 0; b < bias_beats; b++)
			send_beat(16'($urandom()), bias_word(b), 1'b0);  // pixel ignored on bias beats
		if (stray)
			junk_beats(2);  // lands in the finish wait
		go_quiet();
		check_flag("busy", busy, 1'b1);  // still draining
		wait_done();
		check_index(index_pred, exp_index);
		check_value(best_value, exp_value);
		if (stray) begin
			junk_beats(3);  // while done is held
			go_quiet();
			@(negedge clk);
			check_index(index_pred, exp_index);
			check_value(best_value, exp_value);
		end
	endtask

	initial begin
		void'($urandom(32'h3ac2_fc2e));
		reset = 1'b1;
		start = 1'b0;
		data_valid = 1'b0;
		pixel = '0;
		data = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_index(index_pred, '0);
		check_value(best_value, '0);
		junk_beats(2);  // stray beats in idle
		go_quiet();
		@(negedge clk);
		check_flag("busy", busy, 1'b0);

		// neuron 9 well ahead of the rest
		fill_network(16'sd1, 16'sd1, 32'sd0);
		weights[9][5] = 16'sd40;
		biases[9] = 32'sd7;
		run_network(1'b0);

		fill_network(16'sd2, -16'sd3, -32'sd5);  // every neuron below zero
		run_network(1'b0);

		// index 2 in the high bank against index 4 in the low bank
		fill_network(16'sd1, 16'sd0, 32'sd0);
		biases[2] = 32'sd50;
		biases[4] = 32'sd50;
		run_network(1'b0);

		for (int k = 0; k < 20; k++) begin
			randomize_network();
			run_network(1'b0);
		end

		randomize_network();
		run_network(1'b1);  // start pulse and stray beats

		// reset partway through the weight beats
		randomize_network();
		send_start();
		for (int k = 0; k < 12; k++)
			send_beat(pixels[k % num_inputs], weight_word(k / num_inputs, k % num_inputs), 1'b0);
		@(negedge clk);
		check_flag("busy", busy, 1'b1);
		@(posedge clk);
		#2;
		reset = 1'b1;
		data_valid = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_index(index_pred, '0);
		check_value(best_value, '0);
		@(posedge clk);
		#2;
		reset = 1'b0;
		randomize_network();
		run_network(1'b0);

		$display("all tests passed");
		$finish;
	end

endmodule

/* vlog.f */
rtl/mlp_pkg.sv
rtl/bank_if.sv
rtl/layer_seq.sv
rtl/neuron_bank.sv
rtl/max_merge.sv
rtl/mlp_classifier.sv
dv/mlp_classifier_checker.sv
dv/mlp_classifier_tb.sv

/* Makefile */
TOP = mlp_classifier_tb
BIN = obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): vlog.f $(wildcard rtl/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

# pass only when the testbench printed its pass line
run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
